// ==== include/rv_decode_defines.svh ====
`ifndef RV_DECODE_DEFINES_SVH
`define RV_DECODE_DEFINES_SVH

// RV32I base opcodes
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_BRANCH   7'b1100011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_IMM      7'b0010011
`define OP_REG      7'b0110011

// addi x0, x0, 0
`define NOP         32'h0000_0013

// Instruction source, indexed by PC bit 30
`define INST_BIOS   1'b1
`define INST_IMEM   1'b0

// Immediate formats
`define IMM_I       3'd0
`define IMM_S       3'd1
`define IMM_B       3'd2
`define IMM_U       3'd3
`define IMM_J       3'd4

// Target generator modes
`define TGT_NONE    2'd0
`define TGT_JAL     2'd1
`define TGT_BR      2'd2
`define TGT_JALR    2'd3

// Jalr base sources
`define FWD_NONE    2'd0 // Register file
`define FWD_EX      2'd1
`define FWD_MEM     2'd2
`define FWD_WB      2'd3

`endif

// ==== hw/rv_decode_pkg.sv ====
package rv_decode_pkg;

    // One instruction word, read through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_inst_u;

endpackage

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        we,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [1:31]; // x0 has no storage
    logic        wr_en;

    assign wr_en = we && (wa != 5'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= 32'd0;
            end
        end else if (wr_en) begin
            regs[wa] <= wd;
        end
    end

    // Write-through so ID sees the value WB is retiring this cycle
    always_comb begin
        if (ra1 == 5'd0)
            rd1 = 32'd0;
        else if (wr_en && (wa == ra1))
            rd1 = wd;
        else
            rd1 = regs[ra1];

        if (ra2 == 5'd0)
            rd2 = 32'd0;
        else if (wr_en && (wa == ra2))
            rd2 = wd;
        else
            rd2 = regs[ra2];
    end

endmodule

// ==== hw/imm_gen.sv ====
`timescale 1ns/1ps
`include "rv_decode_defines.svh"

module imm_gen
    import rv_decode_pkg::*;
(
    input  rv_inst_u    inst,
    input  logic [2:0]  sel,
    output logic [31:0] imm
);

    always_comb begin
        case (sel)
            `IMM_I: begin
                imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
            end
            `IMM_S: begin
                imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
            end
            `IMM_B: begin // Even offsets only
                imm = {{19{inst.b.imm_12}},
                       inst.b.imm_12,
                       inst.b.imm_11,
                       inst.b.imm_10_5,
                       inst.b.imm_4_1,
                       1'b0};
            end
            `IMM_U: begin
                imm = {inst.u.imm_31_12, 12'd0}; // Upper 20 bits, low bits zero
            end
            `IMM_J: begin
                imm = {{11{inst.j.imm_20}},
                       inst.j.imm_20,
                       inst.j.imm_19_12,
                       inst.j.imm_11,
                       inst.j.imm_10_1,
                       1'b0};
            end
            default: begin
                imm = 32'd0;
            end
        endcase
    end

endmodule

// ==== hw/target_gen.sv ====
`timescale 1ns/1ps
`include "rv_decode_defines.svh"

module target_gen (
    input  logic [31:0] pc,
    input  logic [1:0]  sel,
    input  logic [1:0]  fwd_sel,
    input  logic [31:0] rd1,
    input  logic [31:0] ex_alu,
    input  logic [31:0] mem_alu,
    input  logic [31:0] wb_wdata,
    input  logic [31:0] imm,
    output logic [31:0] target,
    output logic        target_taken,
    output logic        branch_taken
);

    logic [31:0] base;     // Jalr base after forwarding
    logic [31:0] pc_sum;
    logic [31:0] base_sum;

    always_comb begin
        case (fwd_sel)
            `FWD_EX:  base = ex_alu;
            `FWD_MEM: base = mem_alu;
            `FWD_WB:  base = wb_wdata;
            default:  base = rd1;
        endcase
    end

    assign pc_sum   = pc + imm;
    assign base_sum = base + imm;

    always_comb begin
        target       = 32'd0;
        target_taken = 1'b0;
        branch_taken = 1'b0;
        case (sel)
            `TGT_JAL: begin
                target       = pc_sum;
                target_taken = 1'b1;
            end
            `TGT_BR: begin
                // Static prediction, backward taken and forward not taken
                target       = pc_sum;
                target_taken = imm[31];
                branch_taken = imm[31];
            end
            `TGT_JALR: begin
                target       = {base_sum[31:1], 1'b0};
                target_taken = 1'b1;
            end
            default: begin
                target = 32'd0; // No redirect
            end
        endcase
    end

endmodule

// ==== hw/id_control.sv ====
`timescale 1ns/1ps
`include "rv_decode_defines.svh"

module id_control
    import rv_decode_pkg::*;
(
    input  rv_inst_u   inst,
    input  rv_inst_u   ex_inst,
    input  rv_inst_u   mem_inst,
    input  rv_inst_u   wb_inst,
    output logic [2:0] imm_sel,
    output logic [1:0] tgt_sel,
    output logic [1:0] fwd_sel,
    output logic       stall
);

    // Opcodes that produce a register result
    function automatic logic writes_rd(input logic [6:0] op);
        case (op)
            `OP_LUI, `OP_AUIPC, `OP_JAL, `OP_JALR,
            `OP_LOAD, `OP_IMM, `OP_REG: writes_rd = 1'b1;
            default:                    writes_rd = 1'b0;
        endcase
    endfunction

    logic [6:0] opcode;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       uses_rs2;
    logic       ex_hit;
    logic       mem_hit;
    logic       wb_hit;
    logic       ex_load_rs1;
    logic       ex_load_rs2;
    logic       mem_load_rs1;

    assign opcode   = inst.r.opcode;
    assign rs1      = inst.i.rs1;
    assign rs2      = inst.s.rs2;
    assign uses_rs2 = (opcode == `OP_STORE) || (opcode == `OP_BRANCH) || (opcode == `OP_REG);

    assign ex_hit  = writes_rd(ex_inst.r.opcode) && (ex_inst.r.rd != 5'd0)
                     && (ex_inst.r.rd == rs1);
    assign mem_hit = writes_rd(mem_inst.r.opcode) && (mem_inst.r.rd != 5'd0)
                     && (mem_inst.r.rd == rs1);
    assign wb_hit  = writes_rd(wb_inst.r.opcode) && (wb_inst.r.rd != 5'd0)
                     && (wb_inst.r.rd == rs1);

    // Load data is not ready until after MEM
    assign ex_load_rs1  = (ex_inst.i.opcode == `OP_LOAD) && (ex_inst.i.rd != 5'd0)
                          && (ex_inst.i.rd == rs1);
    assign ex_load_rs2  = (ex_inst.i.opcode == `OP_LOAD) && (ex_inst.i.rd != 5'd0)
                          && (ex_inst.i.rd == rs2) && uses_rs2;
    assign mem_load_rs1 = (mem_inst.i.opcode == `OP_LOAD) && (mem_inst.i.rd != 5'd0)
                          && (mem_inst.i.rd == rs1);

    assign stall = ex_load_rs1 || ex_load_rs2 || ((opcode == `OP_JALR) && mem_load_rs1);

    always_comb begin
        if (ex_hit)
            fwd_sel = `FWD_EX;  // Youngest producer wins
        else if (mem_hit)
            fwd_sel = `FWD_MEM;
        else if (wb_hit)
            fwd_sel = `FWD_WB;
        else
            fwd_sel = `FWD_NONE;
    end

    always_comb begin
        imm_sel = `IMM_I;
        tgt_sel = `TGT_NONE;
        case (opcode)
            `OP_STORE:          imm_sel = `IMM_S;
            `OP_LUI, `OP_AUIPC: imm_sel = `IMM_U;
            `OP_BRANCH: begin
                imm_sel = `IMM_B;
                tgt_sel = `TGT_BR;
            end
            `OP_JAL: begin
                imm_sel = `IMM_J;
                tgt_sel = `TGT_JAL;
            end
            `OP_JALR: begin
                tgt_sel = stall ? `TGT_NONE : `TGT_JALR; // Base not valid yet
            end
            default:            imm_sel = `IMM_I;
        endcase
    end

endmodule

// ==== hw/id_stage.sv ====
`timescale 1ns/1ps
`include "rv_decode_defines.svh"

module id_stage
    import rv_decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ex_flush,
    input  logic [31:0] id_pc,
    input  logic [31:0] id_bios_inst,
    input  logic [31:0] id_imem_inst,
    input  logic        wb_regwen,
    input  logic [31:0] ex_alu,   // Forwarded into jalr base
    input  logic [31:0] mem_alu,  // Forwarded into jalr base
    input  logic [31:0] mem_inst, // For hazard and forward checks
    input  logic [31:0] wb_wdata,
    input  logic [31:0] wb_inst,
    output logic [31:0] id_target,
    output logic        id_target_taken,
    output logic        ex_br_taken,
    output logic [31:0] ex_pc,
    output logic [31:0] ex_rd1,
    output logic [31:0] ex_rd2,
    output logic [31:0] ex_imm,
    output logic [31:0] ex_inst,
    output logic        id_stall
);

    rv_inst_u    id_inst;
    logic [4:0]  ra1;
    logic [4:0]  ra2;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [2:0]  imm_sel;
    logic [31:0] imm;
    logic [1:0]  tgt_sel;
    logic [1:0]  fwd_sel;
    logic        br_taken;

    // Boot ROM lives in the upper address region
    always_comb begin
        case (id_pc[30])
            `INST_BIOS: id_inst = id_bios_inst;
            `INST_IMEM: id_inst = id_imem_inst;
            default:    id_inst = id_imem_inst;
        endcase
    end

    assign ra1 = id_inst.r.rs1;
    assign ra2 = id_inst.r.rs2;

    reg_file u_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (wb_regwen),
        .wa    (wb_inst[11:7]),
        .wd    (wb_wdata),
        .ra1   (ra1),
        .ra2   (ra2),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    imm_gen u_imm_gen (
        .inst (id_inst),
        .sel  (imm_sel),
        .imm  (imm)
    );

    id_control u_id_control (
        .inst     (id_inst),
        .ex_inst  (ex_inst),
        .mem_inst (mem_inst),
        .wb_inst  (wb_inst),
        .imm_sel  (imm_sel),
        .tgt_sel  (tgt_sel),
        .fwd_sel  (fwd_sel),
        .stall    (id_stall)
    );

    target_gen u_target_gen (
        .pc           (id_pc),
        .sel          (tgt_sel),
        .fwd_sel      (fwd_sel),
        .rd1          (rd1),
        .ex_alu       (ex_alu),
        .mem_alu      (mem_alu),
        .wb_wdata     (wb_wdata),
        .imm          (imm),
        .target       (id_target),
        .target_taken (id_target_taken),
        .branch_taken (br_taken)
    );

    // ID/EX registers, a bubble is a NOP with zeroed payload
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_pc       <= 32'd0;
            ex_rd1      <= 32'd0;
            ex_rd2      <= 32'd0;
            ex_imm      <= 32'd0;
            ex_br_taken <= 1'b0;
            ex_inst     <= `NOP;
        end else if (id_stall || ex_flush) begin
            ex_pc       <= 32'd0;
            ex_rd1      <= 32'd0;
            ex_rd2      <= 32'd0;
            ex_imm      <= 32'd0;
            ex_br_taken <= 1'b0;
            ex_inst     <= `NOP;
        end else begin
            ex_pc       <= id_pc;
            ex_rd1      <= rd1;
            ex_rd2      <= rd2;
            ex_imm      <= imm;
            ex_br_taken <= br_taken;
            ex_inst     <= id_inst;
        end
    end

endmodule

// ==== dv/id_stage_asserts.sv ====
`timescale 1ns/1ps
`include "rv_decode_defines.svh"

module id_stage_asserts (
    input logic        clk,
    input logic        rst_n,
    input logic        id_stall,
    input logic        ex_flush,
    input logic [31:0] ex_inst,
    input logic [4:0]  ra1,
    input logic [31:0] ex_rd1
);

    // First edge out of reset still shows the reset bubble
    reset_bubble: assert property (@(posedge clk) $rose(rst_n) |-> (ex_inst == `NOP))
        else $error("ex_inst is not a NOP right after reset");

    stall_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        (id_stall || ex_flush) |=> (ex_inst == `NOP))
        else $error("stall or flush did not load a NOP bubble into EX");

    // A read of x0 carries zero into EX
    x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ((ra1 == 5'd0) && !id_stall && !ex_flush) |=> (ex_rd1 == 32'd0))
        else $error("register x0 read back a nonzero value");

endmodule

// ==== dv/id_stage_checker.sv ====
`timescale 1ns/1ps
`include "rv_decode_defines.svh"

module id_stage_checker
    import rv_decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ex_flush,
    input  logic [31:0] id_pc,
    input  logic [31:0] id_bios_inst,
    input  logic [31:0] id_imem_inst,
    input  logic        wb_regwen,
    input  logic [31:0] ex_alu,
    input  logic [31:0] mem_alu,
    input  logic [31:0] mem_inst,
    input  logic [31:0] wb_wdata,
    input  logic [31:0] wb_inst,
    input  logic [31:0] id_target,
    input  logic        id_target_taken,
    input  logic        ex_br_taken,
    input  logic [31:0] ex_pc,
    input  logic [31:0] ex_rd1,
    input  logic [31:0] ex_rd2,
    input  logic [31:0] ex_imm,
    input  logic [31:0] ex_inst,
    input  logic        id_stall,
    output int          error_count,
    output int          check_count
);

    logic [31:0] shadow [0:31];     // Architectural register file model
    logic [31:0] m_pc   = 32'd0;    // Expected ID/EX contents
    logic [31:0] m_rd1  = 32'd0;
    logic [31:0] m_rd2  = 32'd0;
    logic [31:0] m_imm  = 32'd0;
    logic [31:0] m_inst = `NOP;
    logic        m_br   = 1'b0;
    logic        pending = 1'b0;
    int          errors = 0;
    int          checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    function automatic logic has_dest(input logic [6:0] op);
        return (op == `OP_LUI) || (op == `OP_AUIPC) || (op == `OP_JAL) || (op == `OP_JALR)
            || (op == `OP_LOAD) || (op == `OP_IMM) || (op == `OP_REG);
    endfunction

    // Immediate straight from the RV32I encoding tables
    function automatic logic [31:0] expect_imm(input logic [31:0] w);
        case (w[6:0])
            `OP_STORE:          return {{20{w[31]}}, w[31:25], w[11:7]};
            `OP_BRANCH:         return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            `OP_LUI, `OP_AUIPC: return {w[31:12], 12'd0};
            `OP_JAL:            return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:            return {{20{w[31]}}, w[31:20]};
        endcase
    endfunction

    function automatic logic [31:0] read_reg(input logic [4:0] a);
        if (a == 5'd0)
            return 32'd0;
        if (wb_regwen && (wb_inst[11:7] == a))
            return wb_wdata; // Write-through
        return shadow[a];
    endfunction

    function automatic logic load_use_stall(input rv_inst_u d, input rv_inst_u e,
                                            input rv_inst_u m);
        logic use2;
        logic ex_load;
        logic mem_load;
        use2 = (d.r.opcode == `OP_STORE) || (d.r.opcode == `OP_BRANCH)
            || (d.r.opcode == `OP_REG);
        ex_load  = (e.r.opcode == `OP_LOAD) && (e.r.rd != 5'd0);
        mem_load = (m.r.opcode == `OP_LOAD) && (m.r.rd != 5'd0);
        return (ex_load && ((e.r.rd == d.r.rs1) || (use2 && (e.r.rd == d.r.rs2))))
            || ((d.r.opcode == `OP_JALR) && mem_load && (m.r.rd == d.r.rs1));
    endfunction

    function automatic logic [31:0] jalr_base(input rv_inst_u d, input rv_inst_u e);
        rv_inst_u m;
        rv_inst_u w;
        m = mem_inst;
        w = wb_inst;
        if (has_dest(e.r.opcode) && (e.r.rd != 5'd0) && (e.r.rd == d.r.rs1))
            return ex_alu;
        if (has_dest(m.r.opcode) && (m.r.rd != 5'd0) && (m.r.rd == d.r.rs1))
            return mem_alu;
        if (has_dest(w.r.opcode) && (w.r.rd != 5'd0) && (w.r.rd == d.r.rs1))
            return wb_wdata;
        return read_reg(d.r.rs1);
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s at %0t: expected %h actual %h", name, $time, exp, act);
        end
    endtask

    // Inputs settle 1 ns after the rising edge, so the falling edge sees them stable
    always @(negedge clk) begin : check_cycle
        rv_inst_u    d;
        logic [31:0] imm;
        logic [31:0] tgt;
        logic        stall;
        logic        taken;
        logic        br;
        if (pending) begin
            compare("ex_pc", m_pc, ex_pc);
            compare("ex_rd1", m_rd1, ex_rd1);
            compare("ex_rd2", m_rd2, ex_rd2);
            compare("ex_imm", m_imm, ex_imm);
            compare("ex_inst", m_inst, ex_inst);
            compare("ex_br_taken", 32'(m_br), 32'(ex_br_taken));
        end
        d     = id_pc[30] ? id_bios_inst : id_imem_inst;
        imm   = expect_imm(d);
        stall = load_use_stall(d, m_inst, mem_inst);
        tgt   = 32'd0;
        taken = 1'b0;
        br    = 1'b0;
        case (d.r.opcode)
            `OP_JAL: begin
                tgt   = id_pc + imm;
                taken = 1'b1;
            end
            `OP_BRANCH: begin
                tgt   = id_pc + imm;
                taken = imm[31]; // Backward taken
                br    = imm[31];
            end
            `OP_JALR: begin
                if (!stall) begin
                    tgt    = jalr_base(d, m_inst) + imm;
                    tgt[0] = 1'b0;
                    taken  = 1'b1;
                end
            end
            default: begin
                tgt = 32'd0;
            end
        endcase
        compare("id_stall", 32'(stall), 32'(id_stall));
        compare("id_target", tgt, id_target);
        compare("id_target_taken", 32'(taken), 32'(id_target_taken));

        if (!rst_n || stall || ex_flush) begin
            m_pc   = 32'd0;
            m_rd1  = 32'd0;
            m_rd2  = 32'd0;
            m_imm  = 32'd0;
            m_br   = 1'b0;
            m_inst = `NOP;
        end else begin
            m_pc   = id_pc;
            m_rd1  = read_reg(d.r.rs1);
            m_rd2  = read_reg(d.r.rs2);
            m_imm  = imm;
            m_br   = br;
            m_inst = d;
        end

        if (!rst_n) begin
            for (int k = 0; k < 32; k++) begin
                shadow[k[4:0]] = 32'd0;
            end
        end else if (wb_regwen && (wb_inst[11:7] != 5'd0)) begin
            shadow[wb_inst[11:7]] = wb_wdata; // Committed at the coming edge
        end
        pending = 1'b1;
    end

endmodule

// ==== dv/id_stage_tb.sv ====
`timescale 1ns/1ps
`include "rv_decode_defines.svh"

module id_stage_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RST_CYCLES   = 10;
    localparam int DIRECTED_MAX = 40;
    localparam int NUM_RANDOM   = 400;
    // Two cycles per instruction leaves room for stalls and flushes
    localparam int STIM_CYCLES  = RST_CYCLES + 2 * (DIRECTED_MAX + NUM_RANDOM);
    localparam int WATCHDOG_NS  = STIM_CYCLES * 3 / 2 * CLK_PERIOD;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        ex_flush;
    logic [31:0] id_pc;
    logic [31:0] id_bios_inst;
    logic [31:0] id_imem_inst;
    logic        wb_regwen;
    logic [31:0] ex_alu;
    logic [31:0] mem_alu;
    logic [31:0] mem_inst;
    logic [31:0] wb_wdata;
    logic [31:0] wb_inst;
    logic [31:0] id_target;
    logic        id_target_taken;
    logic        ex_br_taken;
    logic [31:0] ex_pc;
    logic [31:0] ex_rd1;
    logic [31:0] ex_rd2;
    logic [31:0] ex_imm;
    logic [31:0] ex_inst;
    logic        id_stall;
    int          error_count;
    int          check_count;
    logic [31:0] lcg_state = 32'd64;
    logic [31:0] prev_ex   = `NOP; // What EX held one cycle back
    logic [31:0] rand_pc;

    always #(CLK_PERIOD / 2) clk = ~clk;

    id_stage uut (
        .clk(clk), .rst_n(rst_n), .ex_flush(ex_flush), .id_pc(id_pc),
        .id_bios_inst(id_bios_inst), .id_imem_inst(id_imem_inst), .wb_regwen(wb_regwen),
        .ex_alu(ex_alu), .mem_alu(mem_alu), .mem_inst(mem_inst), .wb_wdata(wb_wdata),
        .wb_inst(wb_inst), .id_target(id_target), .id_target_taken(id_target_taken),
        .ex_br_taken(ex_br_taken), .ex_pc(ex_pc), .ex_rd1(ex_rd1), .ex_rd2(ex_rd2),
        .ex_imm(ex_imm), .ex_inst(ex_inst), .id_stall(id_stall)
    );

    id_stage_checker chk (
        .clk(clk), .rst_n(rst_n), .ex_flush(ex_flush), .id_pc(id_pc),
        .id_bios_inst(id_bios_inst), .id_imem_inst(id_imem_inst), .wb_regwen(wb_regwen),
        .ex_alu(ex_alu), .mem_alu(mem_alu), .mem_inst(mem_inst), .wb_wdata(wb_wdata),
        .wb_inst(wb_inst), .id_target(id_target), .id_target_taken(id_target_taken),
        .ex_br_taken(ex_br_taken), .ex_pc(ex_pc), .ex_rd1(ex_rd1), .ex_rd2(ex_rd2),
        .ex_imm(ex_imm), .ex_inst(ex_inst), .id_stall(id_stall),
        .error_count(error_count), .check_count(check_count)
    );

    bind id_stage id_stage_asserts u_asserts (
        .clk(clk), .rst_n(rst_n), .id_stall(id_stall), .ex_flush(ex_flush),
        .ex_inst(ex_inst), .ra1(ra1), .ex_rd1(ex_rd1)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Legal opcodes with registers kept to x0..x7 so hazards come up often
    function automatic logic [31:0] rand_inst();
        logic [31:0] r;
        logic [6:0]  op;
        r = next_rand();
        case (next_rand() % 32'd9)
            32'd0:   op = `OP_LUI;
            32'd1:   op = `OP_AUIPC;
            32'd2:   op = `OP_JAL;
            32'd3:   op = `OP_JALR;
            32'd4:   op = `OP_BRANCH;
            32'd5:   op = `OP_LOAD;
            32'd6:   op = `OP_STORE;
            32'd7:   op = `OP_IMM;
            default: op = `OP_REG;
        endcase
        return {r[31:25], 2'b00, r[22:20], 2'b00, r[17:15], r[14:12], 2'b00, r[9:7], op};
    endfunction

    // Other instruction port carries junk to prove the source select
    task automatic present(input logic [31:0] pc, input logic [31:0] inst);
        id_pc = pc;
        if (pc[30]) begin
            id_bios_inst = inst;
            id_imem_inst = next_rand();
        end else begin
            id_imem_inst = inst;
            id_bios_inst = next_rand();
        end
    endtask

    task automatic update_stages();
        logic [31:0] r;
        r         = next_rand();
        wb_inst   = mem_inst;
        mem_inst  = prev_ex;
        prev_ex   = ex_inst;
        wb_regwen = r[0] | r[1];
        wb_wdata  = next_rand();
        ex_alu    = next_rand();
        mem_alu   = next_rand();
    endtask

    // Holds the instruction until a cycle passes without stall or flush
    task automatic issue(input logic [31:0] pc, input logic [31:0] inst, input logic flush);
        logic held;
        held = 1'b1;
        present(pc, inst);
        ex_flush = flush;
        while (held) begin
            @(negedge clk);
            held = id_stall || ex_flush;
            @(posedge clk);
            #1;
            ex_flush = 1'b0;
            update_stages();
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        ex_flush     = 1'b0;
        id_pc        = 32'd0;
        id_bios_inst = `NOP;
        id_imem_inst = `NOP;
        wb_regwen    = 1'b0;
        ex_alu       = 32'd0;
        mem_alu      = 32'd0;
        mem_inst     = `NOP;
        wb_wdata     = 32'd0;
        wb_inst      = `NOP;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Each register write is read back in the same cycle
        for (int k = 0; k < 8; k++) begin
            wb_inst   = {20'd0, k[4:0], `OP_IMM};
            wb_regwen = 1'b1;
            wb_wdata  = 32'hA5A5_0000 + 32'(k);
            issue(32'h0000_0100, {7'd0, 5'd0, k[4:0], 3'd0, 5'd1, `OP_REG}, 1'b0);
        end
        issue(32'h0000_0104, {7'd0, 5'd2, 5'd1, 3'd0, 5'd3, `OP_REG}, 1'b0);

        // Jumps and branches from both instruction sources
        issue(32'h4000_0200, 32'h0100_00EF, 1'b0);
        issue(32'h0000_0200, 32'hFF9F_F0EF, 1'b0);
        issue(32'h4000_0300, 32'hFE20_8EE3, 1'b0);
        issue(32'h0000_0300, 32'h0020_8463, 1'b0);

        // Jalr base from EX, then from MEM
        issue(32'h0000_0400, {12'd1, 5'd0, 3'd0, 5'd5, `OP_IMM}, 1'b0);
        ex_alu = 32'h0000_2001;
        issue(32'h0000_0404, {12'd4, 5'd5, 3'd0, 5'd1, `OP_JALR}, 1'b0);
        issue(32'h0000_0408, {12'd1, 5'd0, 3'd0, 5'd6, `OP_IMM}, 1'b0);
        issue(32'h0000_040C, `NOP, 1'b0);
        mem_alu = 32'h0000_3003;
        issue(32'h0000_0410, {12'd0, 5'd6, 3'd0, 5'd1, `OP_JALR}, 1'b0);

        // Load-use stalls, then a flushed instruction
        issue(32'h0000_0500, {12'd0, 5'd2, 3'b010, 5'd7, `OP_LOAD}, 1'b0);
        issue(32'h0000_0504, {7'd0, 5'd1, 5'd7, 3'd0, 5'd3, `OP_REG}, 1'b0);
        issue(32'h0000_0508, {12'd0, 5'd2, 3'b010, 5'd6, `OP_LOAD}, 1'b0);
        issue(32'h0000_050C, {12'd8, 5'd6, 3'd0, 5'd1, `OP_JALR}, 1'b0);
        issue(32'h0000_0510, {12'd3, 5'd1, 3'd0, 5'd4, `OP_IMM}, 1'b1);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            rand_pc = next_rand() & 32'hFFFF_FFFC;
            issue(rand_pc, rand_inst(), (next_rand() % 32'd16) == 32'd0);
        end
        issue(32'h0000_0600, `NOP, 1'b0);
        issue(32'h0000_0604, `NOP, 1'b0);

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== rv_decode.f ====
+incdir+include
hw/rv_decode_pkg.sv
hw/reg_file.sv
hw/imm_gen.sv
hw/target_gen.sv
hw/id_control.sv
hw/id_stage.sv
dv/id_stage_asserts.sv
dv/id_stage_checker.sv
dv/id_stage_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = id_stage_tb
FILELIST = rv_decode.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
